//--- rtl/xdbl_pkg.sv
// xdbl_pkg: field width, prime, element type and step/opcode enums for the xDBL engine
package xdbl_pkg;

  // single-word field elements of GF(p)
  localparam int WORD_BITS = 16;

  // prime modulus, below 2^WORD_BITS so one conditional subtract reduces a sum
  localparam logic [WORD_BITS-1:0] FIELD_P = 16'd65521;

  // wide enough to index WORD_BITS-1 down to 0
  localparam int BIT_IDX_BITS = 4;

  // field element, value kept below FIELD_P
  typedef logic [WORD_BITS-1:0] fe_t;

  // controller state, also selects datapath operands
  typedef enum logic [2:0] {
    step_idle,
    // t0 = X+Z, t1 = X-Z
    step_sum_diff,
    // t2 = t0^2, t3 = t1^2
    step_square,
    // t4 = t2, t5 = t3, t0 = t2-t3
    step_diff_sq,
    // t2 = C24*t5, t3 = A24*t0
    step_scale,
    // t5 = t2, t1 = t2+t3
    step_sum_sc,
    // t2 = t4*t5, t3 = t1*t0
    step_final,
    step_done
  } xdbl_step_e;

  // add/sub lane opcode
  typedef enum logic {
    op_add,
    op_sub
  } addsub_op_e;

endpackage

//--- rtl/mul_seq_if.sv
// mul_seq_if: sequencing signals shared by controller, bit timer and serial multipliers
`timescale 1ns/1ps

interface mul_seq_if;
  import xdbl_pkg::*;

  // issue pulse, clears the accumulators
  logic mul_start;
  // high during the WORD_BITS iteration cycles
  logic active;
  // multiplier bit consumed this cycle, MSB first
  logic [BIT_IDX_BITS-1:0] bit_idx;
  // final iteration
  logic last;

  modport ctrl (output mul_start, input last);

  modport timer (input mul_start, output active, output bit_idx, output last);

  modport dp (input mul_start, input active, input bit_idx);

endinterface

//--- rtl/mul_timer.sv
// mul_timer: bit counter pacing one MSB-first serial modular multiplication
`timescale 1ns/1ps

module mul_timer (
  input  logic      clk,
  input  logic      rst,
  mul_seq_if.timer  seq
);
  import xdbl_pkg::*;

  logic                    active_q;
  logic [BIT_IDX_BITS-1:0] idx_q;
  logic                    last_w;

  // last iteration once the index has reached bit 0
  assign last_w = active_q && (idx_q == '0);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      active_q <= 1'b0;
      idx_q    <= '0;
    end else if (seq.mul_start) begin
      // start from the top bit of the multiplier
      active_q <= 1'b1;
      idx_q    <= BIT_IDX_BITS'(WORD_BITS - 1);
    end else if (active_q) begin
      if (last_w) begin
        active_q <= 1'b0;
      end else begin
        idx_q <= idx_q - 1'b1;
      end
    end
  end

  assign seq.active  = active_q;
  assign seq.bit_idx = idx_q;
  assign seq.last    = last_w;

endmodule

//--- rtl/mod_mul_serial.sv
// mod_mul_serial: interleaved modular multiplier, one bit of b per cycle from the MSB
`timescale 1ns/1ps

module mod_mul_serial (
  input  logic          clk,
  input  logic          rst,
  input  xdbl_pkg::fe_t a,
  input  xdbl_pkg::fe_t b,
  mul_seq_if.dp         seq,
  output xdbl_pkg::fe_t product
);
  import xdbl_pkg::*;

  fe_t                acc;
  fe_t                acc_nxt;
  logic [WORD_BITS:0] dbl;
  logic [WORD_BITS:0] sum;

  // acc <- 2*acc + b[i]*a, each stage brought back below p
  always_comb begin
    dbl = {acc, 1'b0};
    if (dbl >= {1'b0, FIELD_P}) begin
      dbl = dbl - {1'b0, FIELD_P};
    end
    sum = dbl + (b[seq.bit_idx] ? {1'b0, a} : '0);
    if (sum >= {1'b0, FIELD_P}) begin
      sum = sum - {1'b0, FIELD_P};
    end
    acc_nxt = sum[WORD_BITS-1:0];
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      acc <= '0;
    end else if (seq.mul_start) begin
      acc <= '0;
    end else if (seq.active) begin
      acc <= acc_nxt;
    end
  end

  // final value is ready at the edge that ends the last iteration
  assign product = acc_nxt;

endmodule

//--- rtl/xdbl_ctrl.sv
// xdbl_ctrl: FSM stepping through the six xDBL steps with start/busy/done handshake
`timescale 1ns/1ps

module xdbl_ctrl (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   start,
  output logic                   busy,
  output logic                   done,
  output xdbl_pkg::xdbl_step_e   step,
  output logic                   capture,
  mul_seq_if.ctrl                seq
);
  import xdbl_pkg::*;

  xdbl_step_e state;

  // inputs are loaded at the same edge that accepts start
  assign capture = (state == step_idle) && start;
  assign step    = state;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state         <= step_idle;
      busy          <= 1'b0;
      done          <= 1'b0;
      seq.mul_start <= 1'b0;
    end else begin
      done          <= 1'b0;
      seq.mul_start <= 1'b0;
      case (state)
        step_idle: begin
          if (start) begin
            state <= step_sum_diff;
            busy  <= 1'b1;
          end
        end

        // add steps take a single cycle
        step_sum_diff: begin
          state         <= step_square;
          seq.mul_start <= 1'b1;
        end

        step_square: begin
          if (seq.last) begin
            state <= step_diff_sq;
          end
        end

        step_diff_sq: begin
          state         <= step_scale;
          seq.mul_start <= 1'b1;
        end

        step_scale: begin
          if (seq.last) begin
            state <= step_sum_sc;
          end
        end

        step_sum_sc: begin
          state         <= step_final;
          seq.mul_start <= 1'b1;
        end

        step_final: begin
          if (seq.last) begin
            state <= step_done;
          end
        end

        // done pulses as busy drops
        step_done: begin
          state <= step_idle;
          busy  <= 1'b0;
          done  <= 1'b1;
        end

        default: begin
          state <= step_idle;
          busy  <= 1'b0;
        end
      endcase
    end
  end

endmodule

//--- rtl/xdbl_datapath.sv
// xdbl_datapath: operand registers, per-step routing, two add/sub lanes and two multipliers
`timescale 1ns/1ps

module xdbl_datapath (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 capture,
  input  xdbl_pkg::xdbl_step_e step,
  mul_seq_if.dp                seq,
  input  xdbl_pkg::fe_t        x_in,
  input  xdbl_pkg::fe_t        z_in,
  input  xdbl_pkg::fe_t        a24_in,
  input  xdbl_pkg::fe_t        c24_in,
  output xdbl_pkg::fe_t        x_out,
  output xdbl_pkg::fe_t        z_out
);
  import xdbl_pkg::*;

  // captured inputs
  fe_t x_r, z_r, a24_r, c24_r;
  // intermediates of the doubling formula
  fe_t t0, t1, t2, t3, t4, t5;

  // add/sub lanes
  addsub_op_e op_a, op_b;
  fe_t        add_a_x, add_a_y, add_b_x, add_b_y;
  fe_t        add_a_res, add_b_res;

  // multiplier lanes
  fe_t mul_a_x, mul_a_y, mul_b_x, mul_b_y;
  fe_t mul_a_prod, mul_b_prod;
  logic mul_done;

  // modular add or subtract, one correction step each way
  function automatic fe_t mod_addsub(addsub_op_e op, fe_t x, fe_t y);
    logic [WORD_BITS:0] r;
    if (op == op_add) begin
      r = {1'b0, x} + {1'b0, y};
      if (r >= {1'b0, FIELD_P}) begin
        r = r - {1'b0, FIELD_P};
      end
    end else begin
      r = {1'b0, x} - {1'b0, y};
      if (x < y) begin
        r = r + {1'b0, FIELD_P};
      end
    end
    return r[WORD_BITS-1:0];
  endfunction

  // operand routing per step
  always_comb begin
    op_a    = op_add;
    add_a_x = '0;
    add_a_y = '0;
    op_b    = op_add;
    add_b_x = '0;
    add_b_y = '0;
    mul_a_x = '0;
    mul_a_y = '0;
    mul_b_x = '0;
    mul_b_y = '0;
    case (step)
      step_sum_diff: begin
        add_a_x = x_r;
        add_a_y = z_r;
        op_b    = op_sub;
        add_b_x = x_r;
        add_b_y = z_r;
      end
      step_square: begin
        mul_a_x = t0;
        mul_a_y = t0;
        mul_b_x = t1;
        mul_b_y = t1;
      end
      step_diff_sq: begin
        op_a    = op_sub;
        add_a_x = t2;
        add_a_y = t3;
      end
      step_scale: begin
        mul_a_x = c24_r;
        mul_a_y = t5;
        mul_b_x = a24_r;
        mul_b_y = t0;
      end
      step_sum_sc: begin
        add_b_x = t2;
        add_b_y = t3;
      end
      step_final: begin
        mul_a_x = t4;
        mul_a_y = t5;
        mul_b_x = t1;
        mul_b_y = t0;
      end
      default: begin
      end
    endcase
  end

  assign add_a_res = mod_addsub(op_a, add_a_x, add_a_y);
  assign add_b_res = mod_addsub(op_b, add_b_x, add_b_y);

  mod_mul_serial u_mul_a (
    .clk     (clk),
    .rst     (rst),
    .a       (mul_a_x),
    .b       (mul_a_y),
    .seq     (seq),
    .product (mul_a_prod)
  );

  mod_mul_serial u_mul_b (
    .clk     (clk),
    .rst     (rst),
    .a       (mul_b_x),
    .b       (mul_b_y),
    .seq     (seq),
    .product (mul_b_prod)
  );

  // last iteration of the shared bit timer
  assign mul_done = seq.active && (seq.bit_idx == '0);

  // inputs and add-step results
  always_ff @(posedge clk) begin
    if (capture) begin
      x_r   <= x_in;
      z_r   <= z_in;
      a24_r <= a24_in;
      c24_r <= c24_in;
    end
    case (step)
      step_sum_diff: begin
        t0 <= add_a_res;
        t1 <= add_b_res;
      end
      step_diff_sq: begin
        t4 <= t2;
        t5 <= t3;
        t0 <= add_a_res;
      end
      step_sum_sc: begin
        t5 <= t2;
        t1 <= add_b_res;
      end
      default: begin
      end
    endcase
  end

  // every multiply step lands in t2 and t3, which are also the outputs
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      t2 <= '0;
      t3 <= '0;
    end else if (mul_done && (step == step_square || step == step_scale ||
                              step == step_final)) begin
      t2 <= mul_a_prod;
      t3 <= mul_b_prod;
    end
  end

  assign x_out = t2;
  assign z_out = t3;

endmodule

//--- rtl/xdbl_top.sv
// xdbl_top: Montgomery xDBL point-doubling engine over GF(p)
`timescale 1ns/1ps

module xdbl_top (
  input  logic          clk,
  input  logic          rst,
  input  logic          start,
  input  xdbl_pkg::fe_t x_in,
  input  xdbl_pkg::fe_t z_in,
  input  xdbl_pkg::fe_t a24_in,
  input  xdbl_pkg::fe_t c24_in,
  output logic          busy,
  output logic          done,
  output xdbl_pkg::fe_t x_out,
  output xdbl_pkg::fe_t z_out
);

  xdbl_pkg::xdbl_step_e step;
  logic                 capture;

  // multiply sequencing between controller, timer and both multipliers
  mul_seq_if u_seq ();

  xdbl_ctrl u_ctrl (
    .clk     (clk),
    .rst     (rst),
    .start   (start),
    .busy    (busy),
    .done    (done),
    .step    (step),
    .capture (capture),
    .seq     (u_seq.ctrl)
  );

  mul_timer u_timer (
    .clk (clk),
    .rst (rst),
    .seq (u_seq.timer)
  );

  xdbl_datapath u_datapath (
    .clk     (clk),
    .rst     (rst),
    .capture (capture),
    .step    (step),
    .seq     (u_seq.dp),
    .x_in    (x_in),
    .z_in    (z_in),
    .a24_in  (a24_in),
    .c24_in  (c24_in),
    .x_out   (x_out),
    .z_out   (z_out)
  );

endmodule

//--- bench/xdbl_assert.sv
// xdbl_assert: concurrent checks on the start/busy/done handshake and multiply timing
`timescale 1ns/1ps

module xdbl_assert (
  input logic                 clk,
  input logic                 rst,
  input logic                 busy,
  input logic                 done,
  input xdbl_pkg::xdbl_step_e step,
  input logic                 mul_start,
  input logic                 active,
  input logic                 last
);
  import xdbl_pkg::*;

  // done is a single-cycle pulse
  a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
    else $error("done stayed high for more than one cycle");

  // done comes exactly when busy drops
  a_done_with_busy: assert property (@(posedge clk) disable iff (rst)
    done |-> (!busy && $past(busy)))
    else $error("done without a falling busy");

  a_busy_fall: assert property (@(posedge clk) disable iff (rst) $fell(busy) |-> done)
    else $error("busy fell without done");

  // mul_start only issued inside a multiply step of a running operation
  a_mul_start_step: assert property (@(posedge clk) disable iff (rst)
    mul_start |-> (busy && (step inside {step_square, step_scale, step_final})))
    else $error("mul_start outside a multiply step");

  // final iteration lands WORD_BITS cycles after the issue pulse
  a_mul_length: assert property (@(posedge clk) disable iff (rst)
    mul_start |-> ##WORD_BITS last)
    else $error("last not seen WORD_BITS cycles after mul_start");

  // timer goes idle right after its final iteration
  a_last_ends: assert property (@(posedge clk) disable iff (rst) last |=> !active)
    else $error("timer still active after the last iteration");

endmodule

// handshake and shared multiply sequencing, seen from the top level
bind xdbl_top xdbl_assert u_xdbl_assert (
  .clk       (clk),
  .rst       (rst),
  .busy      (busy),
  .done      (done),
  .step      (step),
  .mul_start (u_seq.mul_start),
  .active    (u_seq.active),
  .last      (u_seq.last)
);

//--- bench/tb_xdbl.sv
// tb_xdbl: directed testbench for the xDBL point-doubling engine with a GF(p) model
`timescale 1ns/1ps

module tb_xdbl;

  localparam longint P          = 65521;
  localparam int     LATENCY    = 55;
  localparam int     NUM_OPS    = 27;
  localparam int     MAX_CYCLES = NUM_OPS * 60 + 200;

  logic        clk;
  logic        rst;
  logic        start;
  logic [15:0] x_in;
  logic [15:0] z_in;
  logic [15:0] a24_in;
  logic [15:0] c24_in;
  logic        busy;
  logic        done;
  logic [15:0] x_out;
  logic [15:0] z_out;

  integer seed = 32'hea478659;
  int     cycle_count = 0;

  xdbl_top u_xdbl_top (
    .clk    (clk),
    .rst    (rst),
    .start  (start),
    .x_in   (x_in),
    .z_in   (z_in),
    .a24_in (a24_in),
    .c24_in (c24_in),
    .busy   (busy),
    .done   (done),
    .x_out  (x_out),
    .z_out  (z_out)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // run limit
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d clock cycles", MAX_CYCLES);
      $display("Test FAILED");
      $fatal(1);
    end
  end

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
    if (got !== expected) begin
      $display("Fail at %0t ns: %s = %0h, expected %0h", $time, name, got, expected);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  // GF(p) arithmetic on wide integers
  function automatic longint add_p(input longint a, input longint b);
    return (a + b) % P;
  endfunction

  function automatic longint sub_p(input longint a, input longint b);
    return (a - b + P) % P;
  endfunction

  function automatic longint mul_p(input longint a, input longint b);
    return (a * b) % P;
  endfunction

  // six-step xDBL sequence
  task automatic xdbl_model(input longint x, input longint z, input longint a24,
                            input longint c24, output longint x_exp, output longint z_exp);
    longint t0, t1, t2, t3, t4, t5;
    t0 = add_p(x, z);
    t1 = sub_p(x, z);
    t2 = mul_p(t0, t0);
    t3 = mul_p(t1, t1);
    t4 = t2;
    t5 = t3;
    t0 = sub_p(t2, t3);
    t2 = mul_p(c24, t5);
    t3 = mul_p(a24, t0);
    t5 = t2;
    t1 = add_p(t2, t3);
    x_exp = mul_p(t4, t5);
    z_exp = mul_p(t1, t0);
  endtask

  function automatic logic [15:0] rand_fe();
    int unsigned r;
    r = $random(seed);
    return 16'(r % P);
  endfunction

  function automatic logic [15:0] near_top();
    int unsigned r;
    r = $random(seed);
    return 16'(P - 1 - (r % 4));
  endfunction

  task automatic apply_reset();
    rst = 1'b1;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  endtask

  // drives one start pulse, returns at the negedge after the accepting edge
  task automatic issue_op(input logic [15:0] x, input logic [15:0] z,
                          input logic [15:0] a24, input logic [15:0] c24);
    x_in   = x;
    z_in   = z;
    a24_in = a24;
    c24_in = c24;
    start  = 1'b1;
    @(negedge clk);
    start  = 1'b0;
    check_value("busy", busy, 1);
  endtask

  // counts cycles until done, busy must stay high meanwhile
  task automatic wait_done(output int cycles);
    cycles = 0;
    while (!done) begin
      @(negedge clk);
      cycles = cycles + 1;
      if (!done) begin
        check_value("busy", busy, 1);
      end
    end
    check_value("busy", busy, 0);
  endtask

  task automatic run_op(input logic [15:0] x, input logic [15:0] z,
                        input logic [15:0] a24, input logic [15:0] c24);
    longint x_exp, z_exp;
    int     cycles;
    xdbl_model(x, z, a24, c24, x_exp, z_exp);
    issue_op(x, z, a24, c24);
    wait_done(cycles);
    check_value("latency", cycles, LATENCY);
    check_value("x_out", x_out, x_exp);
    check_value("z_out", z_out, z_exp);
  endtask

  task automatic test_reset_state();
    check_value("busy", busy, 0);
    check_value("done", done, 0);
    check_value("x_out", x_out, 0);
    check_value("z_out", z_out, 0);
  endtask

  task automatic test_fixed_vectors();
    run_op(16'd5, 16'd3, 16'd7, 16'd4);
    run_op(16'd0, 16'd1, 16'd7, 16'd4);
  endtask

  // every fourth set sits at the top of the field, the next forces x < z
  task automatic test_random_ops();
    logic [15:0] x, z, a24, c24;
    for (int i = 0; i < 20; i++) begin
      if (i % 4 == 0) begin
        x   = near_top();
        z   = near_top();
        a24 = near_top();
        c24 = near_top();
      end else if (i % 4 == 1) begin
        x   = rand_fe() % 16;
        z   = near_top();
        a24 = rand_fe();
        c24 = near_top();
      end else begin
        x   = rand_fe();
        z   = rand_fe();
        a24 = rand_fe();
        c24 = rand_fe();
      end
      run_op(x, z, a24, c24);
    end
  endtask

  task automatic test_latency();
    run_op(rand_fe(), rand_fe(), rand_fe(), rand_fe());
  endtask

  task automatic test_busy_ignored();
    longint x_exp, z_exp;
    int     cycles;
    xdbl_model(16'd1234, 16'd4321, 16'd99, 16'd17, x_exp, z_exp);
    issue_op(16'd1234, 16'd4321, 16'd99, 16'd17);
    repeat (10) @(negedge clk);
    // second start mid-operation with other operands, curve constants included
    x_in   = 16'd11;
    z_in   = 16'd22;
    a24_in = 16'd33;
    c24_in = 16'd44;
    start  = 1'b1;
    @(negedge clk);
    start = 1'b0;
    wait_done(cycles);
    check_value("latency", cycles + 11, LATENCY);
    check_value("x_out", x_out, x_exp);
    check_value("z_out", z_out, z_exp);
  endtask

  task automatic test_hold_and_back_to_back();
    longint x_exp, z_exp;
    xdbl_model(16'd40000, 16'd65000, 16'd3, 16'd65520, x_exp, z_exp);
    run_op(16'd40000, 16'd65000, 16'd3, 16'd65520);
    x_in   = 16'd7;
    z_in   = 16'd8;
    a24_in = 16'd9;
    c24_in = 16'd10;
    repeat (20) begin
      @(negedge clk);
      check_value("done", done, 0);
    end
    check_value("x_out", x_out, x_exp);
    check_value("z_out", z_out, z_exp);
    run_op(16'd100, 16'd200, 16'd300, 16'd400);
    run_op(16'd65520, 16'd65519, 16'd2, 16'd1);
  endtask

  initial begin
    rst    = 1'b1;
    start  = 1'b0;
    x_in   = '0;
    z_in   = '0;
    a24_in = '0;
    c24_in = '0;
    apply_reset();
    test_reset_state();
    test_fixed_vectors();
    test_random_ops();
    test_latency();
    test_busy_ignored();
    test_hold_and_back_to_back();
    $display("Test OK");
    $finish;
  end

endmodule

//--- xdbl.f
rtl/xdbl_pkg.sv
rtl/mul_seq_if.sv
rtl/mul_timer.sv
rtl/mod_mul_serial.sv
rtl/xdbl_ctrl.sv
rtl/xdbl_datapath.sv
rtl/xdbl_top.sv
bench/xdbl_assert.sv
bench/tb_xdbl.sv
